// File: include/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// datapath width
`define RV_XLEN 32
`define RV_NREGS 32

// data memory depth in words, and its word-address width
`define RV_DMEM_WORDS 64
`define RV_DMEM_AW 6

`endif

// File: source/riscv_instr.sv
`default_nettype none

package riscv_instr;

  // major opcodes in bits 6:0
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  // register-register forms
  localparam logic [31:0] ADD   = 32'b0000000_?????_?????_000_?????_0110011;
  localparam logic [31:0] SUB   = 32'b0100000_?????_?????_000_?????_0110011;
  localparam logic [31:0] XOR   = 32'b0000000_?????_?????_100_?????_0110011;
  localparam logic [31:0] OR    = 32'b0000000_?????_?????_110_?????_0110011;
  localparam logic [31:0] AND   = 32'b0000000_?????_?????_111_?????_0110011;
  localparam logic [31:0] SLL   = 32'b0000000_?????_?????_001_?????_0110011;
  localparam logic [31:0] SRL   = 32'b0000000_?????_?????_101_?????_0110011;
  localparam logic [31:0] SRA   = 32'b0100000_?????_?????_101_?????_0110011;

  // immediate forms
  localparam logic [31:0] ADDI  = 32'b????????????_?????_000_?????_0010011;
  localparam logic [31:0] XORI  = 32'b????????????_?????_100_?????_0010011;
  localparam logic [31:0] ORI   = 32'b????????????_?????_110_?????_0010011;
  localparam logic [31:0] ANDI  = 32'b????????????_?????_111_?????_0010011;
  localparam logic [31:0] SLLI  = 32'b0000000_?????_?????_001_?????_0010011;
  localparam logic [31:0] SRLI  = 32'b0000000_?????_?????_101_?????_0010011;
  localparam logic [31:0] SRAI  = 32'b0100000_?????_?????_101_?????_0010011;

  // loads and stores
  localparam logic [31:0] LB    = 32'b????????????_?????_000_?????_0000011;
  localparam logic [31:0] LH    = 32'b????????????_?????_001_?????_0000011;
  localparam logic [31:0] LW    = 32'b????????????_?????_010_?????_0000011;
  localparam logic [31:0] LBU   = 32'b????????????_?????_100_?????_0000011;
  localparam logic [31:0] LHU   = 32'b????????????_?????_101_?????_0000011;
  localparam logic [31:0] SB    = 32'b???????_?????_?????_000_?????_0100011;
  localparam logic [31:0] SH    = 32'b???????_?????_?????_001_?????_0100011;
  localparam logic [31:0] SW    = 32'b???????_?????_?????_010_?????_0100011;

  localparam logic [31:0] BEQ   = 32'b???????_?????_?????_000_?????_1100011;
  localparam logic [31:0] LUI   = 32'b????????????????????_?????_0110111;
  localparam logic [31:0] AUIPC = 32'b????????????????????_?????_0010111;
  localparam logic [31:0] JAL   = 32'b????????????????????_?????_1101111;

endpackage

`default_nettype wire

// File: source/common.sv
`default_nettype none

package common;

  // operations the execute stage ALU understands
  typedef enum logic [3:0] {
    ADD,
    SUB,
    XOR,
    OR,
    AND,
    SLL,
    SRL,
    SRA,
    EQ
  } alu_cmd;

  // data memory access kind where NONE marks non-memory instructions
  typedef enum logic [3:0] {
    NONE,
    LB,
    LH,
    LW,
    LBU,
    LHU,
    SB,
    SH,
    SW
  } mem_access_type;

endpackage

`default_nettype wire

// File: source/id_ex_if.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_config.svh"

interface id_ex_if;

  logic                 valid;
  logic                 ready;
  common::alu_cmd       alu_op;
  common::mem_access_type access;
  logic [`RV_XLEN-1:0]  op1;
  logic [`RV_XLEN-1:0]  op2;
  // rs2 value that stores write to memory
  logic [`RV_XLEN-1:0]  store_data;
  logic [4:0]           rd;
  logic                 wen;

  modport decode (
    output valid, alu_op, access, op1, op2, store_data, rd, wen,
    input  ready
  );

  modport exec (
    input  valid, alu_op, access, op1, op2, store_data, rd, wen,
    output ready
  );

endinterface

`default_nettype wire

// File: source/regfile.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_config.svh"

module regfile (
  input  logic                clock,
  input  logic                reset,
  input  logic [4:0]          rs1,
  input  logic [4:0]          rs2,
  output logic [`RV_XLEN-1:0] rdata1,
  output logic [`RV_XLEN-1:0] rdata2,
  input  logic                we,
  input  logic [4:0]          waddr,
  input  logic [`RV_XLEN-1:0] wdata
);

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];

  assign rdata1 = regs[rs1];
  assign rdata2 = regs[rs2];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 stays zero because reset clears it and no write ever reaches it
  a_x0_zero: assert property (@(posedge clock) disable iff (reset)
    (rs1 != 5'd0 || rdata1 == '0) && (rs2 != 5'd0 || rdata2 == '0));

endmodule

`default_nettype wire

// File: source/decoder.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_config.svh"

module decoder (
  input  logic                clock,
  input  logic                reset,
  input  logic                instr_valid,
  output logic                instr_ready,
  input  logic [31:0]         instruction,
  input  logic [`RV_XLEN-1:0] pc,
  output logic [4:0]          rs1,
  output logic [4:0]          rs2,
  input  logic [`RV_XLEN-1:0] rdata1,
  input  logic [`RV_XLEN-1:0] rdata2,
  id_ex_if.decode             id_ex
);

  riscv_instr::opcode_e   opcode;
  logic [4:0]             rd;
  logic [11:0]            imm_i;
  logic [11:0]            imm_s;
  logic [31:0]            imm_u;
  logic [20:0]            imm_j;
  common::alu_cmd         alu_sel;
  common::mem_access_type access_sel;
  logic [`RV_XLEN-1:0]    op1, op2;
  logic                   wen, reads_rs1, reads_rs2;
  logic                   raw_hazard, slot_free, accept, started;

  assign opcode = riscv_instr::opcode_e'(instruction[6:0]);
  assign rd     = instruction[11:7];
  assign rs1    = instruction[19:15];
  assign rs2    = instruction[24:20];
  assign imm_i  = instruction[31:20];
  assign imm_s  = {instruction[31:25], instruction[11:7]};
  assign imm_u  = {instruction[31:12], 12'h000};
  assign imm_j  = {instruction[31], instruction[19:12], instruction[20],
                   instruction[30:21], 1'b0};

  always_comb begin
    casez (instruction)
      riscv_instr::SUB:                     alu_sel = common::SUB;
      riscv_instr::XOR, riscv_instr::XORI:  alu_sel = common::XOR;
      riscv_instr::OR, riscv_instr::ORI:    alu_sel = common::OR;
      riscv_instr::AND, riscv_instr::ANDI:  alu_sel = common::AND;
      riscv_instr::SLL, riscv_instr::SLLI:  alu_sel = common::SLL;
      riscv_instr::SRL, riscv_instr::SRLI:  alu_sel = common::SRL;
      riscv_instr::SRA, riscv_instr::SRAI:  alu_sel = common::SRA;
      riscv_instr::BEQ:                     alu_sel = common::EQ;
      // adds, address generation, upper immediates and jal
      default:                              alu_sel = common::ADD;
    endcase
    casez (instruction)
      riscv_instr::LB:  access_sel = common::LB;
      riscv_instr::LH:  access_sel = common::LH;
      riscv_instr::LW:  access_sel = common::LW;
      riscv_instr::LBU: access_sel = common::LBU;
      riscv_instr::LHU: access_sel = common::LHU;
      riscv_instr::SB:  access_sel = common::SB;
      riscv_instr::SH:  access_sel = common::SH;
      riscv_instr::SW:  access_sel = common::SW;
      default:          access_sel = common::NONE;
    endcase
  end

  always_comb begin
    op1       = '0;
    op2       = '0;
    wen       = 1'b0;
    reads_rs1 = 1'b0;
    reads_rs2 = 1'b0;
    case (opcode)
      riscv_instr::OPC_OP, riscv_instr::OPC_BRANCH: begin
        op1       = rdata1;
        op2       = rdata2;
        wen       = (opcode == riscv_instr::OPC_OP);
        reads_rs1 = 1'b1;
        reads_rs2 = 1'b1;
      end
      riscv_instr::OPC_OP_IMM, riscv_instr::OPC_LOAD: begin
        op1       = rdata1;
        op2       = {{(`RV_XLEN-12){imm_i[11]}}, imm_i};
        wen       = 1'b1;
        reads_rs1 = 1'b1;
      end
      riscv_instr::OPC_STORE: begin
        op1       = rdata1;
        op2       = {{(`RV_XLEN-12){imm_s[11]}}, imm_s};
        reads_rs1 = 1'b1;
        reads_rs2 = 1'b1;
      end
      riscv_instr::OPC_LUI: begin
        op1 = imm_u;
        wen = 1'b1;
      end
      riscv_instr::OPC_AUIPC: begin
        op1 = imm_u;
        op2 = pc;
        wen = 1'b1;
      end
      riscv_instr::OPC_JAL: begin
        op1 = {{(`RV_XLEN-21){imm_j[20]}}, imm_j};
        op2 = pc;
      end
      default: ;
    endcase
  end

  // no forwarding, so wait until the producer has been written back
  assign raw_hazard = id_ex.valid && id_ex.wen && id_ex.rd != 5'd0 &&
                      ((reads_rs1 && id_ex.rd == rs1) || (reads_rs2 && id_ex.rd == rs2));
  assign slot_free   = !id_ex.valid || id_ex.ready;
  assign instr_ready = started && slot_free && !raw_hazard;
  assign accept      = instr_valid && instr_ready;

  // input held off for the first cycle out of reset
  always_ff @(posedge clock) begin
    if (reset) begin
      started     <= 1'b0;
      id_ex.valid <= 1'b0;
    end else begin
      started <= 1'b1;
      if (slot_free) id_ex.valid <= accept;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      id_ex.alu_op     <= alu_sel;
      id_ex.access     <= access_sel;
      id_ex.op1        <= op1;
      id_ex.op2        <= op2;
      id_ex.store_data <= rdata2;
      id_ex.rd         <= rd;
      id_ex.wen        <= wen;
    end
  end

  a_instr_stable: assert property (@(posedge clock) disable iff (reset)
    instr_valid && !instr_ready |=> $stable(instruction) && $stable(pc));

  a_alu_op_known: assert property (@(posedge clock) disable iff (reset)
    id_ex.valid |-> !$isunknown(id_ex.alu_op));

endmodule

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_config.svh"

module alu (
  input  logic [`RV_XLEN-1:0] a,
  input  logic [`RV_XLEN-1:0] b,
  input  common::alu_cmd      cmd,
  output logic [`RV_XLEN-1:0] y
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    y = '0;
    case (cmd)
      common::ADD: y = a + b;
      common::SUB: y = a - b;
      common::XOR: y = a ^ b;
      common::OR:  y = a | b;
      common::AND: y = a & b;
      common::SLL: y = a << shamt;
      common::SRL: y = a >> shamt;
      common::SRA: y = $signed(a) >>> shamt;
      // branch compare result as 1 or 0
      common::EQ:  y[0] = (a == b);
      default:     y = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/data_mem.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_config.svh"

module data_mem (
  input  logic                   clock,
  input  common::mem_access_type access,
  input  logic [`RV_XLEN-1:0]    addr,
  input  logic [`RV_XLEN-1:0]    wdata,
  input  logic                   write_en,
  output logic [`RV_XLEN-1:0]    rdata
);

  logic [`RV_XLEN-1:0]    mem [`RV_DMEM_WORDS];
  logic [`RV_DMEM_AW-1:0] word_addr;
  logic [`RV_XLEN-1:0]    word, merged;
  logic [7:0]             byte_sel;
  logic [15:0]            half_sel;

  // upper address bits dropped, so accesses wrap
  assign word_addr = addr[`RV_DMEM_AW+1:2];
  assign word      = mem[word_addr];
  assign byte_sel  = word[{addr[1:0], 3'b000} +: 8];
  assign half_sel  = word[{addr[1], 4'b0000} +: 16];

  always_comb begin
    case (access)
      common::LB:  rdata = {{(`RV_XLEN-8){byte_sel[7]}}, byte_sel};
      common::LBU: rdata = {{(`RV_XLEN-8){1'b0}}, byte_sel};
      common::LH:  rdata = {{(`RV_XLEN-16){half_sel[15]}}, half_sel};
      common::LHU: rdata = {{(`RV_XLEN-16){1'b0}}, half_sel};
      default:     rdata = word;
    endcase
  end

  // read-modify-write of the addressed word
  always_comb begin
    merged = word;
    case (access)
      common::SB: merged[{addr[1:0], 3'b000} +: 8] = wdata[7:0];
      common::SH: merged[{addr[1], 4'b0000} +: 16] = wdata[15:0];
      common::SW: merged = wdata;
      default: ;
    endcase
  end

  always_ff @(posedge clock) begin
    if (write_en) mem[word_addr] <= merged;
  end

  a_half_aligned: assert property (@(posedge clock)
    access inside {common::LH, common::LHU, common::SH} |-> !addr[0]);

endmodule

`default_nettype wire

// File: source/exec_stage.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_config.svh"

module exec_stage (
  input  logic                clock,
  input  logic                reset,
  id_ex_if.exec               id_ex,
  output logic                we,
  output logic [4:0]          waddr,
  output logic [`RV_XLEN-1:0] wdata,
  output logic                retire_valid,
  input  logic                retire_ready,
  output logic [4:0]          retire_rd,
  output logic [`RV_XLEN-1:0] retire_value,
  output logic                retire_wen
);

  common::mem_access_type mem_access;
  logic [`RV_XLEN-1:0]    alu_y, load_data, result;
  logic                   is_load, is_store, move;

  alu u_alu (
    .a   (id_ex.op1),
    .b   (id_ex.op2),
    .cmd (id_ex.alu_op),
    .y   (alu_y)
  );

  // memory only sees a real access while id/ex holds an instruction
  assign mem_access = id_ex.valid ? id_ex.access : common::NONE;
  assign is_load    = mem_access inside {common::LB, common::LH, common::LW,
                                         common::LBU, common::LHU};
  assign is_store   = mem_access inside {common::SB, common::SH, common::SW};

  data_mem u_dmem (
    .clock    (clock),
    .access   (mem_access),
    .addr     (alu_y),
    .wdata    (id_ex.store_data),
    .write_en (move && is_store),
    .rdata    (load_data)
  );

  assign result      = is_load ? load_data : alu_y;
  assign id_ex.ready = !retire_valid || retire_ready;
  assign move        = id_ex.valid && id_ex.ready;

  // write-back lands on the same edge the retire record is loaded
  assign we    = move && id_ex.wen;
  assign waddr = id_ex.rd;
  assign wdata = result;

  always_ff @(posedge clock) begin
    if (reset) retire_valid <= 1'b0;
    else if (id_ex.ready) retire_valid <= id_ex.valid;
  end

  always_ff @(posedge clock) begin
    if (move) begin
      retire_rd    <= id_ex.rd;
      retire_value <= result;
      retire_wen   <= id_ex.wen;
    end
  end

  a_retire_hold: assert property (@(posedge clock) disable iff (reset)
    retire_valid && !retire_ready |=> retire_valid && $stable(retire_rd) &&
      $stable(retire_value) && $stable(retire_wen));

endmodule

`default_nettype wire

// File: source/rv_core.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_config.svh"

module rv_core (
  input  logic                clock,
  input  logic                reset,
  input  logic                instr_valid,
  output logic                instr_ready,
  input  logic [31:0]         instruction,
  input  logic [`RV_XLEN-1:0] pc,
  output logic                retire_valid,
  input  logic                retire_ready,
  output logic [4:0]          retire_rd,
  output logic [`RV_XLEN-1:0] retire_value,
  output logic                retire_wen
);

  logic [4:0]          rs1, rs2, waddr;
  logic [`RV_XLEN-1:0] rdata1, rdata2, wdata;
  logic                we;

  id_ex_if id_ex ();

  regfile u_regfile (
    .clock  (clock),
    .reset  (reset),
    .rs1    (rs1),
    .rs2    (rs2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .we     (we),
    .waddr  (waddr),
    .wdata  (wdata)
  );

  decoder u_decoder (
    .clock       (clock),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .instruction (instruction),
    .pc          (pc),
    .rs1         (rs1),
    .rs2         (rs2),
    .rdata1      (rdata1),
    .rdata2      (rdata2),
    .id_ex       (id_ex)
  );

  exec_stage u_exec (
    .clock        (clock),
    .reset        (reset),
    .id_ex        (id_ex),
    .we           (we),
    .waddr        (waddr),
    .wdata        (wdata),
    .retire_valid (retire_valid),
    .retire_ready (retire_ready),
    .retire_rd    (retire_rd),
    .retire_value (retire_value),
    .retire_wen   (retire_wen)
  );

endmodule

`default_nettype wire

// File: dv/tb_rv_core.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_config.svh"

module tb_rv_core;

  logic        clock;
  logic        reset;
  logic        instr_valid;
  logic        instr_ready;
  logic [31:0] instruction;
  logic [31:0] pc;
  logic        retire_valid;
  logic        retire_ready;
  logic [4:0]  retire_rd;
  logic [31:0] retire_value;
  logic        retire_wen;

  // program table and expected retire records in program order
  logic [31:0] prog_instr [$];
  logic [31:0] prog_pc [$];
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_value [$];
  logic        exp_wen [$];
  logic [31:0] next_pc;

  // architectural state of the reference model
  logic [31:0] model_regs [`RV_NREGS];
  logic [31:0] model_mem [`RV_DMEM_WORDS];

  int n;
  int accepted;
  int retired;
  int cycles;
  int value_errors;
  int protocol_errors;

  rv_core DUT (
    .clock        (clock),
    .reset        (reset),
    .instr_valid  (instr_valid),
    .instr_ready  (instr_ready),
    .instruction  (instruction),
    .pc           (pc),
    .retire_valid (retire_valid),
    .retire_ready (retire_ready),
    .retire_rd    (retire_rd),
    .retire_value (retire_value),
    .retire_wen   (retire_wen)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // instruction encoders
  function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, riscv_instr::OPC_OP};
  endfunction

  function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_format(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], riscv_instr::OPC_STORE};
  endfunction

  function automatic logic [31:0] beq_format(input logic [12:0] off, input logic [4:0] rs2,
                                             input logic [4:0] rs1);
    return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], riscv_instr::OPC_BRANCH};
  endfunction

  function automatic logic [31:0] u_format(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] jal_format(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, riscv_instr::OPC_JAL};
  endfunction

  // true when ins reads a nonzero register that prev writes
  function automatic logic depends_on(input logic [31:0] prev, input logic [31:0] ins);
    logic writes, use1, use2;
    writes = prev[11:7] != 5'd0 &&
             prev[6:0] inside {riscv_instr::OPC_OP, riscv_instr::OPC_OP_IMM,
                               riscv_instr::OPC_LOAD, riscv_instr::OPC_LUI,
                               riscv_instr::OPC_AUIPC};
    use1   = ins[6:0] inside {riscv_instr::OPC_OP, riscv_instr::OPC_OP_IMM,
                              riscv_instr::OPC_LOAD, riscv_instr::OPC_STORE,
                              riscv_instr::OPC_BRANCH};
    use2   = ins[6:0] inside {riscv_instr::OPC_OP, riscv_instr::OPC_STORE,
                              riscv_instr::OPC_BRANCH};
    return writes && ((use1 && ins[19:15] == prev[11:7]) ||
                      (use2 && ins[24:20] == prev[11:7]));
  endfunction

  // RV32I arithmetic by funct3 where alt selects SUB and SRA
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      3'b111:  return a & b;
      3'b001:  return a << b[4:0];
      3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      default: return 32'd0;
    endcase
  endfunction

  task automatic reference_step(input logic [31:0] ins, input logic [31:0] at_pc,
                                output logic [31:0] value, output logic wen);
    logic [31:0] a, b, imm_i, imm_s, imm_j, addr, word;
    logic [7:0]  bt;
    logic [15:0] hw;
    logic [`RV_DMEM_AW-1:0] idx;
    a     = model_regs[ins[19:15]];
    b     = model_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    addr  = a + ((ins[6:0] == riscv_instr::OPC_STORE) ? imm_s : imm_i);
    idx   = addr[`RV_DMEM_AW+1:2];
    word  = model_mem[idx];
    bt    = word[{addr[1:0], 3'b000} +: 8];
    hw    = word[{addr[1], 4'b0000} +: 16];
    value = 32'd0;
    wen   = 1'b0;
    case (ins[6:0])
      riscv_instr::OPC_OP: begin
        value = alu_ref(ins[14:12], ins[30], a, b);
        wen   = 1'b1;
      end
      riscv_instr::OPC_OP_IMM: begin
        // bit 30 is only an opcode bit for the right shifts
        value = alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, imm_i);
        wen   = 1'b1;
      end
      riscv_instr::OPC_LOAD: begin
        case (ins[14:12])
          3'b000:  value = {{24{bt[7]}}, bt};
          3'b100:  value = {24'd0, bt};
          3'b001:  value = {{16{hw[15]}}, hw};
          3'b101:  value = {16'd0, hw};
          default: value = word;
        endcase
        wen = 1'b1;
      end
      riscv_instr::OPC_STORE: begin
        value = addr;
        case (ins[14:12])
          3'b000:  model_mem[idx][{addr[1:0], 3'b000} +: 8] = b[7:0];
          3'b001:  model_mem[idx][{addr[1], 4'b0000} +: 16] = b[15:0];
          default: model_mem[idx] = b;
        endcase
      end
      riscv_instr::OPC_BRANCH: value = (a == b) ? 32'd1 : 32'd0;
      riscv_instr::OPC_LUI: begin
        value = {ins[31:12], 12'h000};
        wen   = 1'b1;
      end
      riscv_instr::OPC_AUIPC: begin
        value = {ins[31:12], 12'h000} + at_pc;
        wen   = 1'b1;
      end
      riscv_instr::OPC_JAL: value = at_pc + imm_j;
      default: ;
    endcase
    if (wen && ins[11:7] != 5'd0) model_regs[ins[11:7]] = value;
  endtask

  task automatic put(input logic [31:0] ins);
    prog_instr.push_back(ins);
    prog_pc.push_back(next_pc);
    next_pc = next_pc + 32'd4;
  endtask

  task automatic build_program();
    put(i_format(12'h123, 5'd0, 3'b000, 5'd1, riscv_instr::OPC_OP_IMM));
    put(i_format(12'hffb, 5'd0, 3'b000, 5'd2, riscv_instr::OPC_OP_IMM));
    // x2 read right after it is written
    put(r_format(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
    put(r_format(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
    put(r_format(7'h00, 5'd4, 5'd3, 3'b100, 5'd5));
    put(r_format(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
    put(r_format(7'h00, 5'd6, 5'd5, 3'b111, 5'd7));
    put(i_format(12'h004, 5'd1, 3'b001, 5'd8, riscv_instr::OPC_OP_IMM));
    put(r_format(7'h00, 5'd8, 5'd1, 3'b001, 5'd9));
    put(r_format(7'h00, 5'd1, 5'd2, 3'b101, 5'd10));
    put(r_format(7'h20, 5'd1, 5'd2, 3'b101, 5'd11));
    // srai and srli of a negative value
    put(i_format(12'h401, 5'd2, 3'b101, 5'd12, riscv_instr::OPC_OP_IMM));
    put(i_format(12'h01c, 5'd2, 3'b101, 5'd13, riscv_instr::OPC_OP_IMM));
    put(i_format(12'h7ff, 5'd1, 3'b100, 5'd14, riscv_instr::OPC_OP_IMM));
    put(i_format(12'h0f0, 5'd2, 3'b110, 5'd15, riscv_instr::OPC_OP_IMM));
    put(i_format(12'h0ff, 5'd3, 3'b111, 5'd16, riscv_instr::OPC_OP_IMM));
    put(u_format(20'h80012, 5'd17, riscv_instr::OPC_LUI));
    put(u_format(20'h00345, 5'd18, riscv_instr::OPC_AUIPC));
    // memory base 0x40
    put(i_format(12'h040, 5'd0, 3'b000, 5'd19, riscv_instr::OPC_OP_IMM));
    put(s_format(12'h000, 5'd17, 5'd19, 3'b010));
    put(s_format(12'h004, 5'd2, 5'd19, 3'b010));
    put(s_format(12'h001, 5'd1, 5'd19, 3'b000));
    put(s_format(12'h006, 5'd4, 5'd19, 3'b001));
    put(i_format(12'h001, 5'd19, 3'b000, 5'd20, riscv_instr::OPC_LOAD));
    put(i_format(12'h003, 5'd19, 3'b000, 5'd28, riscv_instr::OPC_LOAD));
    put(i_format(12'h003, 5'd19, 3'b100, 5'd21, riscv_instr::OPC_LOAD));
    put(i_format(12'h006, 5'd19, 3'b001, 5'd22, riscv_instr::OPC_LOAD));
    put(i_format(12'h004, 5'd19, 3'b101, 5'd23, riscv_instr::OPC_LOAD));
    put(i_format(12'h000, 5'd19, 3'b010, 5'd24, riscv_instr::OPC_LOAD));
    // write x0 and read it back
    put(i_format(12'h005, 5'd1, 3'b000, 5'd0, riscv_instr::OPC_OP_IMM));
    put(r_format(7'h00, 5'd1, 5'd0, 3'b000, 5'd25));
    put(beq_format(13'h010, 5'd1, 5'd1));
    put(beq_format(13'h010, 5'd2, 5'd1));
    put(jal_format(21'h000100, 5'd26));
    put(i_format(12'h001, 5'd1, 3'b000, 5'd1, riscv_instr::OPC_OP_IMM));
    put(i_format(12'h001, 5'd1, 3'b000, 5'd1, riscv_instr::OPC_OP_IMM));
    put(r_format(7'h00, 5'd1, 5'd1, 3'b000, 5'd27));
  endtask

  // build and predict the program, then reset and drive it
  initial begin
    logic [31:0] value;
    logic        wen;
    logic [31:0] gap_state;
    logic        back_to_back;
    reset           = 1'b1;
    instr_valid     = 1'b0;
    instruction     = 32'd0;
    pc              = 32'd0;
    next_pc         = 32'h0000_0100;
    accepted        = 0;
    retired         = 0;
    value_errors    = 0;
    protocol_errors = 0;
    back_to_back    = 1'b0;
    gap_state       = 32'd52179 ^ 32'h9e37_79b9;
    for (int r = 0; r < `RV_NREGS; r++) model_regs[r] = 32'd0;
    build_program();
    n = prog_instr.size();
    for (int i = 0; i < n; i++) begin
      reference_step(prog_instr[i], prog_pc[i], value, wen);
      exp_rd.push_back(prog_instr[i][11:7]);
      exp_value.push_back(value);
      exp_wen.push_back(wen);
    end

    repeat (16) @(posedge clock);
    #1;
    reset = 1'b0;

    for (int i = 0; i < n; i++) begin
      instr_valid = 1'b1;
      instruction = prog_instr[i];
      pc          = prog_pc[i];
      @(negedge clock);
      // the producer accepted on the last edge is still in id/ex
      if (back_to_back && i > 0 && depends_on(prog_instr[i-1], prog_instr[i])) begin
        assert (!instr_ready) else begin
          $display("instr_ready was high although the previous result was not written back");
          protocol_errors++;
        end
      end
      while (!instr_ready) @(negedge clock);
      @(posedge clock);
      #1;
      accepted++;
      back_to_back = 1'b1;
      // an idle gap now and then
      gap_state = xorshift(gap_state);
      if (gap_state[2:0] == 3'd0) begin
        back_to_back = 1'b0;
        instr_valid  = 1'b0;
        repeat (int'(gap_state[4:3]) + 1) @(posedge clock);
        #1;
      end
    end
    instr_valid = 1'b0;

    while (retired < n) @(posedge clock);
    // a few more cycles to catch any extra retire
    repeat (10) @(posedge clock);
    $display("retired %0d of %0d, value errors %0d, protocol errors %0d",
             retired, n, value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // retire_ready high about 3 cycles in 4
  initial begin
    logic [31:0] ready_state;
    ready_state  = 32'd52179;
    retire_ready = 1'b0;
    repeat (16) @(posedge clock);
    forever begin
      #1;
      ready_state  = xorshift(ready_state);
      retire_ready = ready_state[1:0] != 2'b00;
      @(posedge clock);
    end
  end

  // retire records sampled mid-cycle where all inputs are settled
  initial begin
    forever begin
      @(negedge clock);
      if (reset) begin
        assert (!instr_ready && !retire_valid) else begin
          $display("instr_ready or retire_valid was high during reset");
          protocol_errors++;
        end
      end else begin
        assert (!retire_valid || accepted > 0) else begin
          $display("retire_valid went high before any instruction was accepted");
          protocol_errors++;
        end
        if (retire_valid && retire_ready) begin
          assert (retired < n && retired < accepted) else begin
            $display("a retire record appeared with no instruction left to retire");
            protocol_errors++;
          end
          if (retired < n) begin
            assert (retire_rd === exp_rd[retired] && retire_value === exp_value[retired] &&
                    retire_wen === exp_wen[retired]) else begin
              $display("Error at %0t: retire %0d got rd %0d value %h wen %b, expected %0d %h %b",
                       $time, retired, retire_rd, retire_value, retire_wen,
                       exp_rd[retired], exp_value[retired], exp_wen[retired]);
              value_errors++;
            end
          end
          retired++;
        end
      end
    end
  end

  // run limit of 40 cycles per table entry plus 100
  initial begin
    cycles = 0;
    while (cycles <= 40 * n + 100) begin
      @(posedge clock);
      cycles++;
    end
    $display("timeout: only %0d of %0d instructions retired after %0d cycles",
             retired, n, cycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
source/riscv_instr.sv
source/common.sv
source/id_ex_if.sv
source/regfile.sv
source/decoder.sv
source/alu.sv
source/data_mem.sv
source/exec_stage.sv
source/rv_core.sv
dv/tb_rv_core.sv

// File: run.sh
#!/bin/sh
# build the rv_core testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ns -f verilog.f \
  --top-module tb_rv_core -Mdir obj_dir -o sim_tb_rv_core &&
  ./obj_dir/sim_tb_rv_core > sim.log 2>&1 || echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -qx "TEST OK" sim.log && exit 0 || exit 1
